/* Bender.yml */
package:
  name: cache_perf_monitor

sources:
  - files:
      - hw/cache_perf_pkg.sv
      - hw/cache_event_counters.sv
      - hw/perf_snapshot_sampler.sv
      - hw/hex_report_formatter.sv
      - hw/wb_byte_writer.sv
      - hw/cache_perf_monitor.sv
  - target: test
    files:
      - verification/cache_perf_sva.sv
      - verification/cache_perf_tb.sv

/* hw/cache_event_counters.sv */
`timescale 1ns/1ps

module cache_event_counters (
	input  logic                          clk,
	input  logic                          rstn,
	input  cache_perf_pkg::cache_events_t events_i,
	output cache_perf_pkg::event_counts_t counts_o
);
	import cache_perf_pkg::*;

	logic [NUM_EVENTS-1:0] ev_now;
	logic [NUM_EVENTS-1:0] ev_prev_q;
	logic [NUM_EVENTS-1:0] ev_rise;
	perf_count_t [NUM_EVENTS-1:0] cnt_q;

	assign ev_now = events_i;

	// low on the last edge, high on this one
	assign ev_rise = ev_now & ~ev_prev_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ev_prev_q <= '0;
		end else begin
			ev_prev_q <= ev_now;
		end
	end

	// one counter per line, wraps at 4096
	always_ff @(posedge clk) begin
		if (!rstn) begin
			cnt_q <= '0;
		end else begin
			for (int i = 0; i < NUM_EVENTS; i++) begin
				if (ev_rise[i]) begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
				end
			end
		end
	end

	// element order matches the struct field order, l1i_read on top
	assign counts_o = cnt_q;

endmodule

/* hw/cache_perf_monitor.sv */
`timescale 1ns/1ps

module cache_perf_monitor (
	input  logic                          clk,
	input  logic                          rstn,
	input  cache_perf_pkg::cache_events_t events_i,
	input  logic                          wb_ack_i,
	output cache_perf_pkg::wb_req_t       wb_o
);
	import cache_perf_pkg::*;

	event_counts_t counts;
	perf_snapshot_t snapshot;
	logic start;
	logic busy;
	logic char_valid;
	logic char_ready;
	char_t char_data;

	cache_event_counters u_counters (
		.clk      (clk),
		.rstn     (rstn),
		.events_i (events_i),
		.counts_o (counts)
	);

	perf_snapshot_sampler u_sampler (
		.clk        (clk),
		.rstn       (rstn),
		.counts_i   (counts),
		.busy_i     (busy),
		.snapshot_o (snapshot),
		.start_o    (start)
	);

	// snapshot stays put while busy, so the report reads it directly
	hex_report_formatter u_formatter (
		.clk          (clk),
		.rstn         (rstn),
		.start_i      (start),
		.snapshot_i   (snapshot),
		.char_ready_i (char_ready),
		.char_valid_o (char_valid),
		.char_data_o  (char_data),
		.busy_o       (busy)
	);

	wb_byte_writer u_writer (
		.clk          (clk),
		.rstn         (rstn),
		.char_valid_i (char_valid),
		.char_data_i  (char_data),
		.wb_ack_i     (wb_ack_i),
		.char_ready_o (char_ready),
		.wb_o         (wb_o)
	);

endmodule

/* hw/cache_perf_pkg.sv */
package cache_perf_pkg;

	typedef logic [11:0] perf_count_t;
	typedef logic [7:0] char_t;

	// level-type event lines, one bit each
	typedef struct packed {
		logic l1i_read;
		logic l1i_miss;
		logic l1d_read;
		logic l1d_write;
		logic l1d_miss;
		logic l2_read;
		logic l2_write;
		logic l2_miss;
	} cache_events_t;

	typedef struct packed {
		perf_count_t l1i_read;
		perf_count_t l1i_miss;
		perf_count_t l1d_read;
		perf_count_t l1d_write;
		perf_count_t l1d_miss;
		perf_count_t l2_read;
		perf_count_t l2_write;
		perf_count_t l2_miss;
	} event_counts_t;

	typedef struct packed {
		perf_count_t l1i_miss;
		perf_count_t l1i_access;
		perf_count_t l1d_miss;
		perf_count_t l1d_access;
		perf_count_t l2_miss;
		perf_count_t l2_access;
	} perf_snapshot_t;

	// master side of a classic Wishbone write to a byte register
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		char_t dat;
	} wb_req_t;

	localparam int NUM_EVENTS = 8;
	localparam int SAMPLE_PERIOD = 256;
	localparam int TIMER_W = $clog2(SAMPLE_PERIOD);
	localparam int REPORT_LEN = 21;
	localparam int LEVEL_LEN = 7;
	localparam int IDX_W = $clog2(REPORT_LEN);

	localparam char_t TAG_L1I = "a";
	localparam char_t TAG_L1D = "b";
	localparam char_t TAG_L2 = "c";

	typedef enum logic {FMT_IDLE, FMT_EMIT} fmt_state_t;
	typedef enum logic {WB_IDLE, WB_BUSY} wb_state_t;

endpackage

/* hw/hex_report_formatter.sv */
`timescale 1ns/1ps

module hex_report_formatter (
	input  logic                           clk,
	input  logic                           rstn,
	input  logic                           start_i,
	input  cache_perf_pkg::perf_snapshot_t snapshot_i,
	input  logic                           char_ready_i,
	output logic                           char_valid_o,
	output cache_perf_pkg::char_t          char_data_o,
	output logic                           busy_o
);
	import cache_perf_pkg::*;

	fmt_state_t state_q;
	logic [IDX_W-1:0] idx_q;
	logic xfer;
	logic last;
	logic [1:0] lvl;
	logic [2:0] pos;
	logic [23:0] pair;
	logic [3:0] nib;
	char_t tag;

	function automatic char_t hex_char(input logic [3:0] n);
		if (n < 4'd10) begin
			return char_t'(8'h30 + n);
		end
		// 0x37 + 10 lands on 'A'
		return char_t'(8'h37 + n);
	endfunction

	// split the index into level and position within the level
	always_comb begin
		if (idx_q < IDX_W'(LEVEL_LEN)) begin
			lvl = 2'd0;
			pos = idx_q[2:0];
		end else if (idx_q < IDX_W'(2 * LEVEL_LEN)) begin
			lvl = 2'd1;
			pos = 3'(idx_q - IDX_W'(LEVEL_LEN));
		end else begin
			lvl = 2'd2;
			pos = 3'(idx_q - IDX_W'(2 * LEVEL_LEN));
		end
	end

	always_comb begin
		case (lvl)
			2'd0: begin
				tag = TAG_L1I;
				pair = {snapshot_i.l1i_miss, snapshot_i.l1i_access};
			end
			2'd1: begin
				tag = TAG_L1D;
				pair = {snapshot_i.l1d_miss, snapshot_i.l1d_access};
			end
			default: begin
				tag = TAG_L2;
				pair = {snapshot_i.l2_miss, snapshot_i.l2_access};
			end
		endcase
	end

	// miss nibbles first, high to low, then access
	always_comb begin
		case (pos)
			3'd1: nib = pair[23:20];
			3'd2: nib = pair[19:16];
			3'd3: nib = pair[15:12];
			3'd4: nib = pair[11:8];
			3'd5: nib = pair[7:4];
			default: nib = pair[3:0];
		endcase
	end

	assign char_data_o = (pos == 3'd0) ? tag : hex_char(nib);
	assign char_valid_o = (state_q == FMT_EMIT);
	assign busy_o = char_valid_o;
	assign xfer = char_valid_o & char_ready_i;
	assign last = (idx_q == IDX_W'(REPORT_LEN - 1));

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= FMT_IDLE;
			idx_q <= '0;
		end else begin
			case (state_q)
				FMT_IDLE: begin
					if (start_i) begin
						state_q <= FMT_EMIT;
						idx_q <= '0;
					end
				end
				FMT_EMIT: begin
					if (xfer && last) begin
						state_q <= FMT_IDLE;
						idx_q <= '0;
					end else if (xfer) begin
						idx_q <= idx_q + 1'b1;
					end
				end
				default: state_q <= FMT_IDLE;
			endcase
		end
	end

endmodule

/* hw/perf_snapshot_sampler.sv */
`timescale 1ns/1ps

module perf_snapshot_sampler (
	input  logic                           clk,
	input  logic                           rstn,
	input  cache_perf_pkg::event_counts_t  counts_i,
	input  logic                           busy_i,
	output cache_perf_pkg::perf_snapshot_t snapshot_o,
	output logic                           start_o
);
	import cache_perf_pkg::*;

	logic [TIMER_W-1:0] timer_q;
	logic tick;
	logic take;
	logic start_q;
	perf_snapshot_t snap_q;

	assign tick = (timer_q == TIMER_W'(SAMPLE_PERIOD - 1));

	// a tick during a report is simply skipped
	assign take = tick & ~busy_i;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			timer_q <= '0;
		end else if (tick) begin
			timer_q <= '0;
		end else begin
			timer_q <= timer_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			start_q <= 1'b0;
		end else begin
			start_q <= take;
		end
	end

	// access sums wrap at 12 bits like the counters
	always_ff @(posedge clk) begin
		if (take) begin
			snap_q.l1i_miss <= counts_i.l1i_miss;
			snap_q.l1i_access <= counts_i.l1i_read;
			snap_q.l1d_miss <= counts_i.l1d_miss;
			snap_q.l1d_access <= counts_i.l1d_read + counts_i.l1d_write;
			snap_q.l2_miss <= counts_i.l2_miss;
			snap_q.l2_access <= counts_i.l2_read + counts_i.l2_write;
		end
	end

	assign snapshot_o = snap_q;
	assign start_o = start_q;

endmodule

/* hw/wb_byte_writer.sv */
`timescale 1ns/1ps

module wb_byte_writer (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic                    char_valid_i,
	input  cache_perf_pkg::char_t   char_data_i,
	input  logic                    wb_ack_i,
	output logic                    char_ready_o,
	output cache_perf_pkg::wb_req_t wb_o
);
	import cache_perf_pkg::*;

	wb_state_t state_q;
	char_t dat_q;
	logic xfer;
	logic bus_active;

	assign char_ready_o = (state_q == WB_IDLE);
	assign xfer = char_valid_i & char_ready_o;
	assign bus_active = (state_q == WB_BUSY);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= WB_IDLE;
		end else begin
			case (state_q)
				WB_IDLE: begin
					if (xfer) begin
						state_q <= WB_BUSY;
					end
				end
				WB_BUSY: begin
					// cycle ends on the edge that sees ack
					if (wb_ack_i) begin
						state_q <= WB_IDLE;
					end
				end
				default: state_q <= WB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (xfer) begin
			dat_q <= char_data_i;
		end
	end

	// single write, so cyc, stb and we move together
	always_comb begin
		wb_o.cyc = bus_active;
		wb_o.stb = bus_active;
		wb_o.we = bus_active;
		wb_o.dat = dat_q;
	end

endmodule

/* sources.f */
hw/cache_perf_pkg.sv
hw/cache_event_counters.sv
hw/perf_snapshot_sampler.sv
hw/hex_report_formatter.sv
hw/wb_byte_writer.sv
hw/cache_perf_monitor.sv
verification/cache_perf_sva.sv
verification/cache_perf_tb.sv

/* verification/cache_perf_sva.sv */
`timescale 1ns/1ps

module cache_perf_sva (
	input logic                    clk,
	input logic                    rstn,
	input cache_perf_pkg::wb_req_t wb_i,
	input logic                    wb_ack_i
);

	// a strobe only ever comes as part of a write cycle
	property stb_in_write_cycle;
		@(posedge clk) disable iff (!rstn)
			wb_i.stb |-> (wb_i.cyc && wb_i.we);
	endproperty

	property dat_held_until_ack;
		@(posedge clk) disable iff (!rstn)
			(wb_i.stb && !wb_ack_i) |=> $stable(wb_i.dat);
	endproperty

	// reset is synchronous, so cyc is low from the edge after rstn is seen low
	property cyc_low_in_reset;
		@(posedge clk) !rstn |=> !wb_i.cyc;
	endproperty

	assert property (stb_in_write_cycle) else $error("stb high without cyc and we");
	assert property (dat_held_until_ack) else $error("dat changed before ack");
	assert property (cyc_low_in_reset) else $error("cyc high during reset");

endmodule

bind wb_byte_writer cache_perf_sva u_sva (
	.clk      (clk),
	.rstn     (rstn),
	.wb_i     (wb_o),
	.wb_ack_i (wb_ack_i)
);

/* verification/cache_perf_tb.sv */
`timescale 1ns/1ps

module cache_perf_tb;
	import cache_perf_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_INTERVALS = 8;
	localparam int LINE_WORDS = 9;
	localparam int MAX_PULSES = 31;

	logic clk;
	logic rstn;
	logic wb_ack;
	cache_events_t events;
	wb_req_t wb_req;

	logic [7:0] vec_mem [0:NUM_INTERVALS*LINE_WORDS-1];
	perf_count_t exp_cnt [8];
	char_t exp_q [$];
	int cyc_cnt;
	int rx_count;
	integer ack_wait;
	integer seed;

	cache_perf_monitor uut (
		.clk      (clk),
		.rstn     (rstn),
		.events_i (events),
		.wb_ack_i (wb_ack),
		.wb_o     (wb_req)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// cycles since reset release, matches the sampler timer
	always @(posedge clk) begin
		if (!rstn) begin
			cyc_cnt <= 0;
		end else begin
			cyc_cnt <= cyc_cnt + 1;
		end
	end

	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	function automatic char_t hex_digit(input logic [3:0] n);
		string digits;
		digits = "0123456789ABCDEF";
		return char_t'(digits[n]);
	endfunction

	task automatic push_level(input char_t tag, input perf_count_t miss, input perf_count_t acc);
		exp_q.push_back(tag);
		for (int i = 2; i >= 0; i--) begin
			exp_q.push_back(hex_digit(miss[i*4 +: 4]));
		end
		for (int i = 2; i >= 0; i--) begin
			exp_q.push_back(hex_digit(acc[i*4 +: 4]));
		end
	endtask

	// accesses of the data L1 and L2 are read plus write
	task automatic push_report();
		perf_count_t l1d_acc;
		perf_count_t l2_acc;
		l1d_acc = exp_cnt[2] + exp_cnt[3];
		l2_acc = exp_cnt[5] + exp_cnt[6];
		push_level(TAG_L1I, exp_cnt[1], exp_cnt[0]);
		push_level(TAG_L1D, exp_cnt[4], l1d_acc);
		push_level(TAG_L2, exp_cnt[7], l2_acc);
	endtask

	task automatic check_vectors();
		for (int k = 0; k < NUM_INTERVALS; k++) begin
			assert (vec_mem[k*LINE_WORDS + 8] inside {[1:3]}) else begin
				$display("Vector line %0d has a missing or invalid hold length", k);
				fail_run();
			end
			for (int j = 0; j < 8; j++) begin
				assert (vec_mem[k*LINE_WORDS + j] <= MAX_PULSES) else begin
					$display("Vector line %0d asks for too many pulses on line %0d", k, j);
					fail_run();
				end
			end
		end
	endtask

	task automatic drive_pulses(input int bit_idx, input int n, input int hold);
		for (int i = 0; i < n; i++) begin
			events[bit_idx] = 1'b1;
			repeat (hold) @(negedge clk);
			events[bit_idx] = 1'b0;
			@(negedge clk);
		end
	endtask

	// file column j drives struct bit 7-j, l1i_read first
	task automatic run_interval(input int k);
		int base;
		int hold;
		base = k * LINE_WORDS;
		hold = vec_mem[base + 8];
		fork
			drive_pulses(7, vec_mem[base + 0], hold);
			drive_pulses(6, vec_mem[base + 1], hold);
			drive_pulses(5, vec_mem[base + 2], hold);
			drive_pulses(4, vec_mem[base + 3], hold);
			drive_pulses(3, vec_mem[base + 4], hold);
			drive_pulses(2, vec_mem[base + 5], hold);
			drive_pulses(1, vec_mem[base + 6], hold);
			drive_pulses(0, vec_mem[base + 7], hold);
		join
		for (int j = 0; j < 8; j++) begin
			exp_cnt[j] = exp_cnt[j] + perf_count_t'(vec_mem[base + j]);
		end
	endtask

	task automatic check_char(input char_t got);
		int rep;
		int pos;
		char_t exp;
		string name;
		rep = rx_count / REPORT_LEN;
		pos = rx_count % REPORT_LEN;
		name = $sformatf("report %0d char %0d", rep, pos);
		assert (exp_q.size() > 0) else begin
			$display("Write of %h arrived while no report was due", got);
			fail_run();
		end
		assert (cyc_cnt > (rep + 1) * SAMPLE_PERIOD && cyc_cnt <= (rep + 2) * SAMPLE_PERIOD)
		else begin
			$display("%s arrived outside the interval after its sampling tick", name);
			fail_run();
		end
		exp = exp_q.pop_front();
		assert (got == exp) else begin
			$display("[ERROR] %s: expected %h '%c', actual %h '%c'", name, exp, exp, got, got);
			fail_run();
		end
		rx_count++;
	endtask

	// byte sink, acks after 0 to 3 cycles
	always @(negedge clk) begin
		if (!rstn) begin
			wb_ack = 1'b0;
			ack_wait = -1;
		end else if (wb_ack) begin
			wb_ack = 1'b0;
		end else if (wb_req.cyc && wb_req.stb) begin
			assert (cyc_cnt > SAMPLE_PERIOD) else begin
				$display("Wishbone cycle started before the first report was due");
				fail_run();
			end
			assert (wb_req.we) else begin
				$display("Wishbone cycle to the byte sink is not a write");
				fail_run();
			end
			if (ack_wait < 0) begin
				ack_wait = $unsigned($random(seed)) % 4;
			end
			if (ack_wait == 0) begin
				check_char(wb_req.dat);
				wb_ack = 1'b1;
				ack_wait = -1;
			end else begin
				ack_wait = ack_wait - 1;
			end
		end
	end

	initial begin
		#((NUM_INTERVALS + 2) * SAMPLE_PERIOD * CLK_PERIOD);
		$display("Watchdog expired before all reports arrived");
		fail_run();
	end

	initial begin
		events = '0;
		wb_ack = 1'b0;
		rstn = 1'b0;
		seed = 32'hd7a1;
		rx_count = 0;
		for (int j = 0; j < 8; j++) begin
			exp_cnt[j] = '0;
		end
		$readmemh("verification/cache_perf_vectors.txt", vec_mem);
		check_vectors();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		for (int k = 0; k < NUM_INTERVALS; k++) begin
			run_interval(k);
			// second half stays idle until the sampling tick
			while (cyc_cnt < (k + 1) * SAMPLE_PERIOD) @(negedge clk);
			push_report();
		end
		wait (rx_count == NUM_INTERVALS * REPORT_LEN);
		// a stray extra write before the next tick is caught by the sink
		repeat (SAMPLE_PERIOD / 2) @(negedge clk);
		$display("Simulation passed");
		$finish;
	end

endmodule

/* verification/cache_perf_vectors.txt */
// one line per interval: pulse counts for l1i_read l1i_miss l1d_read l1d_write
// l1d_miss l2_read l2_write l2_miss, then the hold length in cycles (1 to 3)
0c 0a 05 06 0b 03 04 0f 01
1f 02 1e 1d 03 0a 0b 01 02
00 00 00 00 00 00 00 00 03
1a 1b 1c 0d 0e 1f 10 11 03
1f 1f 1f 1f 1f 1f 1f 1f 02
01 00 02 00 03 00 04 00 01
1f 1e 1f 1f 1d 1f 1f 1c 03
11 05 19 0a 07 13 1b 09 02
